// File: hdl/trivium_defines.svh
// trivium stream cipher parameters
// widths, warm-up length and queue depth shared by the rtl
`ifndef TRIVIUM_DEFINES_SVH
`define TRIVIUM_DEFINES_SVH

// key and iv widths from the cipher spec
`define TRIV_KEY_BITS 80
`define TRIV_IV_BITS 80

// three shift registers, 93 + 84 + 111 bits
`define TRIV_STATE_BITS 288

// unroll factor, also bits per keystream byte
`define TRIV_ROUNDS_PER_CYCLE 8

// 1152 init rounds at 8 per clock
`define TRIV_WARMUP_CYCLES 144

// entries per queue
`define TRIV_FIFO_DEPTH 8

`endif

// File: hdl/trivium_pkg.sv
// trivium stream types
// key, iv, keystream byte, data beat and core phase
`include "trivium_defines.svh"

package trivium_pkg;

    // cipher inputs
    typedef logic [`TRIV_KEY_BITS-1:0] key_t;
    typedef logic [`TRIV_IV_BITS-1:0] iv_t;

    // one clock of keystream, first round in bit 0
    typedef logic [`TRIV_ROUNDS_PER_CYCLE-1:0] ks_byte_t;

    // plaintext beat as queued
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } data_beat_t;

    // core FSM
    typedef enum logic [1:0] {
        IDLE,
        WARMUP,
        RUN
    } core_phase_e;

endpackage

// File: hdl/payload_fifo.sv
// show-ahead synchronous queue
// circular buffer with occupancy count, head valid whenever not empty,
// flush empties it in one clock
`include "trivium_defines.svh"

module payload_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);
    localparam int DEPTH = `TRIV_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    payload_t         mem [0:DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // push while full is dropped
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers and count, flush wins over push and pop
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: hdl/trivium_core.sv
// trivium keystream core
// loads key and iv, runs 1152 warm-up rounds at 8 per clock,
// then emits one keystream byte per clock while its queue has room
`include "trivium_defines.svh"

module trivium_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  trivium_pkg::key_t   key,
    input  trivium_pkg::iv_t    iv,
    input  logic                ks_full,
    output logic                ks_push,
    output trivium_pkg::ks_byte_t ks_byte,
    output logic                ks_ready
);
    import trivium_pkg::*;

    localparam int ROUNDS = `TRIV_ROUNDS_PER_CYCLE;
    localparam int SB = `TRIV_STATE_BITS;
    localparam int IV_BASE = 93;
    localparam int CNT_W = $clog2(`TRIV_WARMUP_CYCLES);
    localparam logic [CNT_W-1:0] LAST_WARM = CNT_W'(`TRIV_WARMUP_CYCLES - 1);

    core_phase_e      phase;
    logic [CNT_W-1:0] warm_cnt;
    logic [SB-1:0]    state;
    logic [SB-1:0]    init_state;
    logic [SB-1:0]    stage [0:ROUNDS];
    ks_byte_t         z;
    logic             advance;

    // one trivium round, returns {z, next state}
    // index 0 holds s1
    function automatic logic [SB:0] trivium_round(input logic [SB-1:0] s);
        logic t1;
        logic t2;
        logic t3;
        logic z_bit;
        t1 = s[65] ^ s[92];
        t2 = s[161] ^ s[176];
        t3 = s[242] ^ s[287];
        z_bit = t1 ^ t2 ^ t3;
        // nonlinear feedback terms
        t1 = t1 ^ (s[90] & s[91]) ^ s[170];
        t2 = t2 ^ (s[174] & s[175]) ^ s[263];
        t3 = t3 ^ (s[285] & s[286]) ^ s[68];
        // shift each register by one, feedback enters at its low end
        return {z_bit, s[286:177], t2, s[175:93], t1, s[91:0], t3};
    endfunction

    // key in s1..s80, iv in s94..s173, last three bits set
    always_comb begin
        init_state = '0;
        init_state[`TRIV_KEY_BITS-1:0] = key;
        init_state[IV_BASE +: `TRIV_IV_BITS] = iv;
        init_state[SB-1:SB-3] = 3'b111;
    end

    // 8 rounds unrolled, round r gives output bit r
    always_comb begin
        stage[0] = state;
        for (int r = 0; r < ROUNDS; r++) begin
            {z[r], stage[r+1]} = trivium_round(stage[r]);
        end
    end

    // warm-up always advances, run only when the byte can be stored
    assign advance = (phase == WARMUP) || ((phase == RUN) && !ks_full);

    assign ks_push  = (phase == RUN) && !ks_full;
    assign ks_byte  = z;
    assign ks_ready = (phase == RUN);

    // phase and warm-up count
    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= IDLE;
            warm_cnt <= '0;
        end else if (load) begin
            // restart from any phase
            phase    <= WARMUP;
            warm_cnt <= '0;
        end else if (phase == WARMUP) begin
            warm_cnt <= warm_cnt + 1'b1;
            if (warm_cnt == LAST_WARM) begin
                phase <= RUN;
            end
        end
    end

    // cipher state, holds while stalled
    always_ff @(posedge clk) begin
        if (load) begin
            state <= init_state;
        end else if (advance) begin
            state <= stage[ROUNDS];
        end
    end

endmodule

// File: hdl/stream_combiner.sv
// keystream / plaintext combiner
// pops both queues together and registers the xor beat
module stream_combiner (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ks_empty,
    input  trivium_pkg::ks_byte_t   ks_head,
    input  logic                    pt_empty,
    input  trivium_pkg::data_beat_t pt_head,
    output logic                    pop,
    output logic                    ct_valid,
    output logic [7:0]              ct_data,
    output logic                    ct_last
);

    // one pop drives both queues, so they stay in step
    assign pop = !ks_empty && !pt_empty;

    // output strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            ct_valid <= 1'b0;
        end else begin
            ct_valid <= pop;
        end
    end

    // beat payload, only meaningful with ct_valid
    always_ff @(posedge clk) begin
        if (pop) begin
            ct_data <= pt_head.data ^ ks_head;
            ct_last <= pt_head.last;
        end
    end

endmodule

// File: hdl/trivium_stream_top.sv
// trivium stream encryptor
// keystream core and plaintext source feed two queues,
// combiner xors their heads into the ciphertext stream
module trivium_stream_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  trivium_pkg::key_t key,
    input  trivium_pkg::iv_t  iv,
    input  logic              pt_push,
    input  logic [7:0]        pt_data,
    input  logic              pt_last,
    output logic              pt_full,
    output logic              ks_ready,
    output logic              ct_valid,
    output logic [7:0]        ct_data,
    output logic              ct_last
);
    import trivium_pkg::*;

    // core to keystream queue
    logic       ks_push;
    ks_byte_t   ks_byte;
    logic       ks_full;

    // queue heads to combiner
    ks_byte_t   ks_head;
    logic       ks_empty;
    data_beat_t pt_beat;
    data_beat_t pt_head;
    logic       pt_empty;
    logic       pop;

    assign pt_beat.data = pt_data;
    assign pt_beat.last = pt_last;

    trivium_core core0 (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .key      (key),
        .iv       (iv),
        .ks_full  (ks_full),
        .ks_push  (ks_push),
        .ks_byte  (ks_byte),
        .ks_ready (ks_ready)
    );

    // load drops stale keystream
    payload_fifo #(.payload_t(ks_byte_t)) ks_fifo (
        .clk       (clk),
        .rst       (rst),
        .flush     (load),
        .push      (ks_push),
        .push_data (ks_byte),
        .pop       (pop),
        .head      (ks_head),
        .empty     (ks_empty),
        .full      (ks_full)
    );

    // pending plaintext also dropped on load
    payload_fifo #(.payload_t(data_beat_t)) pt_fifo (
        .clk       (clk),
        .rst       (rst),
        .flush     (load),
        .push      (pt_push),
        .push_data (pt_beat),
        .pop       (pop),
        .head      (pt_head),
        .empty     (pt_empty),
        .full      (pt_full)
    );

    stream_combiner comb0 (
        .clk      (clk),
        .rst      (rst),
        .ks_empty (ks_empty),
        .ks_head  (ks_head),
        .pt_empty (pt_empty),
        .pt_head  (pt_head),
        .pop      (pop),
        .ct_valid (ct_valid),
        .ct_data  (ct_data),
        .ct_last  (ct_last)
    );

endmodule

// File: dv/trivium_stream_tb.sv
// trivium stream testbench
// bit-serial reference model, scoreboard of pushed plaintext beats,
// assertions on every ciphertext beat and on ks_ready timing
`include "trivium_defines.svh"

module trivium_stream_tb;
    import trivium_pkg::*;

    localparam int NUM_TESTS = 6;
    localparam int TEST_CYCLES = 2000;

    logic       clk;
    logic       rst;
    logic       load;
    key_t       key;
    iv_t        iv;
    logic       pt_push;
    logic [7:0] pt_data;
    logic       pt_last;
    logic       pt_full;
    logic       ks_ready;
    logic       ct_valid;
    logic [7:0] ct_data;
    logic       ct_last;

    // scoreboard, model and expected head beat
    data_beat_t   sb[$];
    logic [287:0] model_state;
    logic [7:0]   model_byte;
    logic         exp_avail = 1'b0;
    logic [7:0]   exp_data;
    logic         exp_last;
    logic         beat_seen;
    logic         loaded;
    int           since_load;
    int           rx_count = 0;
    int           errors = 0;
    int           test_errs = 0;
    int           tests_passed = 0;
    int           tests_failed = 0;
    string        test_name = "reset";

    trivium_stream_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic note_failure(input string msg);
        errors++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic value_error(input string what, input int expv, input int actv);
        errors++;
        $display("ERROR %s: %s expected %0h, actual %0h", test_name, what, expv, actv);
    endtask

    // one round, s1 at index 0
    task automatic model_round(output logic z);
        logic t1;
        logic t2;
        logic t3;
        t1 = model_state[65] ^ model_state[92];
        t2 = model_state[161] ^ model_state[176];
        t3 = model_state[242] ^ model_state[287];
        z = t1 ^ t2 ^ t3;
        t1 = t1 ^ (model_state[90] & model_state[91]) ^ model_state[170];
        t2 = t2 ^ (model_state[174] & model_state[175]) ^ model_state[263];
        t3 = t3 ^ (model_state[285] & model_state[286]) ^ model_state[68];
        // all bits move up one place, register heads take the feedback
        model_state = {model_state[286:0], 1'b0};
        model_state[0] = t3;
        model_state[93] = t1;
        model_state[177] = t2;
    endtask

    // first round lands in bit 0
    task automatic model_next_byte();
        logic z;
        for (int r = 0; r < 8; r++) begin
            model_round(z);
            model_byte[r] = z;
        end
    endtask

    task automatic model_init(input key_t k, input iv_t v);
        logic z;
        model_state = '0;
        for (int i = 0; i < 80; i++) begin
            model_state[i] = k[i];
            model_state[93 + i] = v[i];
        end
        model_state[287:285] = 3'b111;
        for (int i = 0; i < 1152; i++) begin
            model_round(z);
        end
        model_next_byte();
    endtask

    task automatic refresh_expect();
        exp_avail = (sb.size() != 0);
        if (sb.size() != 0) begin
            exp_data = sb[0].data ^ model_byte;
            exp_last = sb[0].last;
        end
    endtask

    function automatic logic [79:0] random_80();
        logic [95:0] r;
        r = {$urandom(), $urandom(), $urandom()};
        return r[79:0];
    endfunction

    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = $urandom();
        return r[7:0];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        if (errors == test_errs) begin
            tests_passed++;
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", test_name, errors - test_errs);
        end
    endtask

    // new key, pending beats in the DUT are flushed along with the scoreboard
    task automatic load_cipher(input key_t k, input iv_t v);
        load = 1'b1;
        key = k;
        iv = v;
        sb.delete();
        model_init(k, v);
        refresh_expect();
        next_cycle();
        load = 1'b0;
    endtask

    task automatic push_beat(input logic [7:0] d, input logic l);
        while (pt_full) begin
            next_cycle();
        end
        pt_push = 1'b1;
        pt_data = d;
        pt_last = l;
        sb.push_back(data_beat_t'{data: d, last: l});
        refresh_expect();
        next_cycle();
        pt_push = 1'b0;
    endtask

    // last flag only on the final beat
    task automatic push_burst(input int n, input int gap_max, input bit zero_data);
        int gap;
        for (int i = 0; i < n; i++) begin
            push_beat(zero_data ? 8'h00 : random_byte(), i == n - 1);
            gap = $urandom() % (gap_max + 1);
            repeat (gap) next_cycle();
        end
    endtask

    task automatic wait_drain();
        while (sb.size() != 0) begin
            next_cycle();
        end
        repeat (4) next_cycle();
    endtask

    task automatic wait_ready();
        while (!ks_ready) begin
            next_cycle();
        end
    endtask

    // edges since the load edge, that edge counts as 1
    always @(posedge clk) begin
        if (rst) begin
            loaded <= 1'b0;
            since_load <= 0;
        end else if (load) begin
            loaded <= 1'b1;
            since_load <= 1;
        end else if (since_load < 100000) begin
            since_load <= since_load + 1;
        end
    end

    // count every DUT beat, retire the one checked at the last falling edge
    initial begin
        forever begin
            @(negedge clk);
            beat_seen = ct_valid && !rst;
            @(posedge clk);
            #2;
            if (beat_seen) begin
                rx_count++;
                if (sb.size() != 0) begin
                    void'(sb.pop_front());
                    model_next_byte();
                    refresh_expect();
                end
            end
        end
    end

    a_owed: assert property (@(negedge clk) disable iff (rst) ct_valid |-> exp_avail)
        else note_failure("ciphertext beat with no plaintext pending");
    a_data: assert property (@(negedge clk) disable iff (rst)
        (ct_valid && exp_avail) |-> (ct_data == exp_data))
        else value_error("ct_data", int'(exp_data), int'(ct_data));
    a_last: assert property (@(negedge clk) disable iff (rst)
        (ct_valid && exp_avail) |-> (ct_last == exp_last))
        else value_error("ct_last", int'(exp_last), int'(ct_last));
    a_quiet: assert property (@(negedge clk) disable iff (rst)
        !loaded |-> (!ct_valid && !ks_ready))
        else note_failure("output activity before any load");
    a_rise: assert property (@(negedge clk) disable iff (rst)
        $rose(ks_ready) |-> (since_load == 145))
        else value_error("ks_ready delay", 145, since_load);
    // ks_ready may only fall right after a load
    a_hold: assert property (@(negedge clk) disable iff (rst)
        $fell(ks_ready) |-> (since_load == 1))
        else note_failure("ks_ready dropped without a load");

    // watchdog, 2000 cycles per test
    initial begin
        repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int n;
        int rx_start;
        logic [287:0] stall_state;
        void'($urandom(32'ha1f8_f745));
        rst = 1'b1;
        load = 1'b0;
        key = '0;
        iv = '0;
        pt_push = 1'b0;
        pt_data = '0;
        pt_last = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test("reset_idle");
        assert (!ct_valid && !ks_ready && !pt_full)
            else note_failure("outputs not low after reset");
        // plaintext with no cipher loaded stays parked
        push_burst(3, 1, 1'b0);
        repeat (20) next_cycle();
        end_test();

        start_test("ready_timing");
        load_cipher(random_80(), random_80());
        wait_ready();
        repeat (30) next_cycle();
        assert (ks_ready) else note_failure("ks_ready low while running");
        end_test();

        // zero plaintext gives the raw keystream
        start_test("zero_key");
        rx_start = rx_count;
        load_cipher('0, '0);
        push_burst(16, 0, 1'b1);
        wait_drain();
        assert (rx_count - rx_start == 16)
            else value_error("beat count", 16, rx_count - rx_start);
        end_test();

        // burst starts during warm-up
        start_test("random_burst");
        load_cipher(random_80(), random_80());
        n = $urandom() % 17;
        push_burst(n + 24, 3, 1'b0);
        wait_drain();
        end_test();

        start_test("backpressure");
        load_cipher(random_80(), random_80());
        n = 0;
        while (!pt_full) begin
            push_beat(random_byte(), 1'b0);
            n++;
            assert (pt_full == (n >= `TRIV_FIFO_DEPTH))
                else value_error("pt_full", int'(n >= `TRIV_FIFO_DEPTH), int'(pt_full));
        end
        wait_ready();
        repeat (50) next_cycle();
        // cipher state must not move while the queue is full
        stall_state = dut0.core0.state;
        next_cycle();
        assert (dut0.ks_full && dut0.core0.state == stall_state)
            else note_failure("core did not stall on a full keystream queue");
        push_burst(20, 0, 1'b0);
        wait_drain();
        end_test();

        // beats parked during warm-up must vanish on the second load
        start_test("reload");
        load_cipher(random_80(), random_80());
        push_burst(5, 1, 1'b0);
        repeat (40) next_cycle();
        rx_start = rx_count;
        load_cipher(random_80(), random_80());
        push_burst(12, 2, 1'b0);
        wait_drain();
        assert (rx_count - rx_start == 12)
            else value_error("beat count", 12, rx_count - rx_start);
        end_test();

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: trivium_stream.f
+incdir+hdl
hdl/trivium_pkg.sv
hdl/payload_fifo.sv
hdl/trivium_core.sv
hdl/stream_combiner.sv
hdl/trivium_stream_top.sv
dv/trivium_stream_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the trivium stream testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module trivium_stream_tb \
    -f trivium_stream.f \
    --Mdir obj_dir -o trivium_stream_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/trivium_stream_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
